// ==== tb.f ====
design/corePkg.sv
design/controlDecoder.sv
design/regFile.sv
design/aluExecute.sv
design/resultStage.sv
design/miniCore.sv
testbench/tbMiniCore.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tbMiniCore -f tb.f -o simMiniCore \
	|| { echo "Build failed"; exit 1; }
out=$(./obj_dir/simMiniCore)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== testbench/tbMiniCore.sv ====
`timescale 1ns/1ps

module tbMiniCore;

	localparam int ClkPeriod = 20;
	localparam int NumAlu = 300;
	localparam int NumCond = 200;
	localparam int NumBad = 60;
	localparam int NumHaltTail = 20;
	// Two resets of twelve cycles plus every issued instruction
	localparam int TotalInstr = 2 * 12 + 16 + 16 + NumAlu + NumCond + NumBad + 8 + 1
		+ NumHaltTail + 2;
	localparam int WatchdogCycles = TotalInstr + 50;

	typedef struct packed {
		logic valid;
		corePkg::regIdx_t idx;
		corePkg::word_t data;
		logic illegal;
		logic halted;
	} expect_t;

	logic clk = 1'b0;
	logic rstN;
	logic instValid;
	corePkg::instr_t instr;
	logic wbValid;
	corePkg::regIdx_t wbIdx;
	corePkg::word_t wbData;
	logic illegal;
	logic halted;

	int seed = 71668;
	string testName;
	corePkg::word_t modelRegs [corePkg::RegCount];
	logic modelHalted;
	corePkg::regIdx_t lastDest;
	expect_t pending [$];

	corePkg::opcode_t aluOpcs [10] = '{corePkg::OpcAddi, corePkg::OpcSubi, corePkg::OpcXori,
		corePkg::OpcAndni, corePkg::OpcRoli, corePkg::OpcSlli, corePkg::OpcRori,
		corePkg::OpcSrli, corePkg::OpcShiftR, corePkg::OpcAluR};
	corePkg::opcode_t condOpcs [7] = '{corePkg::OpcSeq, corePkg::OpcSlt, corePkg::OpcSle,
		corePkg::OpcSco, corePkg::OpcLbi, corePkg::OpcSlbi, corePkg::OpcBtr};
	// Memory, branch, jump and trap opcodes that the core does not implement
	corePkg::opcode_t badOpcs [13] = '{5'b00010, 5'b00011, 5'b00100, 5'b00101, 5'b00110,
		5'b00111, 5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b10000, 5'b10001, 5'b10011};

	miniCore i_miniCore (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbIdx(wbIdx),
		.wbData(wbData),
		.illegal(illegal),
		.halted(halted)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// kind 0 is register and immediate ALU, 1 is compares and loads, 2 is unlisted
	function automatic corePkg::instr_t randInstr(input int kind);
		corePkg::opcode_t opc;
		case (kind)
			0: opc = aluOpcs[randBelow(10)];
			1: opc = condOpcs[randBelow(7)];
			default: opc = badOpcs[randBelow(13)];
		endcase
		return {opc, 11'(randBelow(2048))};
	endfunction

	// Reference model, updates the register copy and returns next cycle's outputs
	function automatic expect_t modelInstr(input corePkg::instr_t ins, input logic valid);
		expect_t e;
		corePkg::opcode_t opc;
		corePkg::regIdx_t dest;
		corePkg::word_t a;
		corePkg::word_t b;
		corePkg::word_t simm;
		corePkg::word_t zimm;
		corePkg::word_t rev;
		corePkg::word_t result;
		logic [16:0] wide;
		int shImm;
		int shReg;
		logic live;
		logic wr;
		logic bad;
		logic haltNow;
		e = '0;
		opc = ins[15:11];
		a = modelRegs[ins[10:8]];
		b = modelRegs[ins[7:5]];
		simm = {{11{ins[4]}}, ins[4:0]};
		zimm = {11'b0, ins[4:0]};
		shImm = int'(ins[3:0]);
		shReg = int'(b[3:0]);
		wide = {1'b0, a} + {1'b0, b};
		for (int i = 0; i < 16; i++)
			rev[i] = a[15 - i];
		live = valid && !modelHalted;
		result = '0;
		wr = 1'b1;
		bad = 1'b0;
		haltNow = 1'b0;
		if (opc inside {corePkg::OpcAddi, corePkg::OpcSubi, corePkg::OpcXori, corePkg::OpcAndni,
				corePkg::OpcRoli, corePkg::OpcSlli, corePkg::OpcRori, corePkg::OpcSrli})
			dest = ins[7:5];
		else if (opc == corePkg::OpcLbi || opc == corePkg::OpcSlbi)
			dest = ins[10:8];
		else
			dest = ins[4:2];
		case (opc)
			corePkg::OpcAddi: result = a + simm;
			corePkg::OpcSubi: result = simm - a;
			corePkg::OpcXori: result = a ^ zimm;
			corePkg::OpcAndni: result = a & ~zimm;
			corePkg::OpcRoli: result = (a << shImm) | (a >> (16 - shImm));
			corePkg::OpcSlli: result = a << shImm;
			corePkg::OpcRori: result = (a >> shImm) | (a << (16 - shImm));
			corePkg::OpcSrli: result = a >> shImm;
			corePkg::OpcShiftR:
				case (ins[1:0])
					2'd0: result = (a << shReg) | (a >> (16 - shReg));
					2'd1: result = a << shReg;
					2'd2: result = (a >> shReg) | (a << (16 - shReg));
					default: result = a >> shReg;
				endcase
			corePkg::OpcAluR:
				case (ins[1:0])
					2'd0: result = a + b;
					2'd1: result = b - a;
					2'd2: result = a ^ b;
					default: result = a & ~b;
				endcase
			corePkg::OpcSeq: result = {15'b0, a == b};
			corePkg::OpcSlt: result = {15'b0, $signed(a) < $signed(b)};
			corePkg::OpcSle: result = {15'b0, $signed(a) <= $signed(b)};
			corePkg::OpcSco: result = {15'b0, wide[16]};
			corePkg::OpcLbi: result = {{8{ins[7]}}, ins[7:0]};
			corePkg::OpcSlbi: result = {a[7:0], ins[7:0]};
			corePkg::OpcBtr: result = rev;
			corePkg::OpcNop: wr = 1'b0;
			corePkg::OpcHalt:
			begin
				wr = 1'b0;
				haltNow = 1'b1;
			end
			default:
			begin
				wr = 1'b0;
				bad = 1'b1;
			end
		endcase
		if (live && wr)
		begin
			modelRegs[dest] = result;
			e.valid = 1'b1;
			e.idx = dest;
			e.data = result;
		end
		e.illegal = live && bad;
		if (live && haltNow)
			modelHalted = 1'b1;
		e.halted = modelHalted;
		return e;
	endfunction

	task automatic checkWord(input string what, input corePkg::word_t exp,
		input corePkg::word_t act);
		if (exp !== act)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", testName, what, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkIdx(input string what, input corePkg::regIdx_t exp,
		input corePkg::regIdx_t act);
		if (exp !== act)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", testName, what, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("CHECK FAILED %s %s: expected %b, actual %b", testName, what, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkOutputs();
		expect_t e;
		if (pending.size() > 0)
		begin
			e = pending.pop_front();
			checkBit("wbValid", e.valid, wbValid);
			checkBit("illegal", e.illegal, illegal);
			checkBit("halted", e.halted, halted);
			if (e.valid)
			begin
				checkIdx("wbIdx", e.idx, wbIdx);
				checkWord("wbData", e.data, wbData);
			end
		end
	endtask

	// Outputs of the previous instruction are stable 2 ns after the edge that sampled it
	task automatic issue(input corePkg::instr_t ins, input logic valid);
		expect_t e;
		@(posedge clk);
		#2;
		checkOutputs();
		instr = ins;
		instValid = valid;
		e = modelInstr(ins, valid);
		pending.push_back(e);
		if (e.valid)
			lastDest = e.idx;
	endtask

	task automatic resetCore();
		@(posedge clk);
		#2;
		checkOutputs();
		rstN = 1'b0;
		instValid = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
		for (int i = 0; i < corePkg::RegCount; i++)
			modelRegs[i] = '0;
		modelHalted = 1'b0;
		pending.delete();
		checkBit("wbValid", 1'b0, wbValid);
		checkBit("illegal", 1'b0, illegal);
		checkBit("halted", 1'b0, halted);
	endtask

	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		corePkg::instr_t ins;
		rstN = 1'b0;
		instValid = 1'b0;
		instr = '0;
		lastDest = '0;
		testName = "reset";
		resetCore();
		for (int i = 0; i < corePkg::RegCount; i++)
			issue({corePkg::OpcAluR, 3'(i), 3'(i), 3'(i), corePkg::FnAdd}, 1'b1);
		for (int i = 0; i < corePkg::RegCount; i++)
			issue({corePkg::OpcLbi, 3'(i), 8'h00}, 1'b1);

		testName = "alu";
		for (int i = 0; i < corePkg::RegCount; i++)
		begin
			issue({corePkg::OpcLbi, 3'(i), 8'(randBelow(256))}, 1'b1);
			issue({corePkg::OpcSlbi, 3'(i), 8'(randBelow(256))}, 1'b1);
		end
		for (int n = 0; n < NumAlu; n++)
		begin
			ins = randInstr((randBelow(16) == 0) ? 2 : 0);
			// Dependent pair reads the register written one cycle earlier
			if (randBelow(3) == 0)
				ins[10:8] = lastDest;
			issue(ins, randBelow(8) != 0);
		end

		testName = "cond";
		for (int n = 0; n < NumCond; n++)
		begin
			ins = randInstr(1);
			if (randBelow(4) == 0)
				ins[7:5] = ins[10:8];
			issue(ins, 1'b1);
		end

		testName = "illegal";
		for (int n = 0; n < NumBad; n++)
		begin
			if (randBelow(4) == 0)
				ins = {corePkg::OpcNop, 11'(randBelow(2048))};
			else
				ins = randInstr(2);
			issue(ins, 1'b1);
		end
		for (int i = 0; i < corePkg::RegCount; i++)
			issue({corePkg::OpcAluR, 3'(i), 3'(i), 3'(i), corePkg::FnAdd}, 1'b1);

		testName = "halt";
		issue({corePkg::OpcHalt, 11'(randBelow(2048))}, 1'b1);
		for (int n = 0; n < NumHaltTail; n++)
			issue(randInstr(randBelow(2)), 1'b1);
		resetCore();
		issue({corePkg::OpcAddi, 3'd1, 3'd2, 5'd7}, 1'b1);
		issue('0, 1'b0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== design/miniCore.sv ====
`timescale 1ns/1ps

module miniCore (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input corePkg::instr_t instr,
	output logic wbValid,
	output corePkg::regIdx_t wbIdx,
	output corePkg::word_t wbData,
	output logic illegal,
	output logic halted
);

	corePkg::ctrl_t ctrl;
	corePkg::exRes_t res;
	corePkg::regIdx_t rsIdx;
	corePkg::regIdx_t rtIdx;
	corePkg::regIdx_t destIdx;
	corePkg::regIdx_t wrIdx;
	corePkg::word_t imm;
	corePkg::word_t rsData;
	corePkg::word_t rtData;
	corePkg::word_t wrData;
	logic wrEn;

	controlDecoder i_controlDecoder (
		.instr(instr),
		.ctrl(ctrl),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.destIdx(destIdx),
		.imm(imm)
	);

	regFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.rsData(rsData),
		.rtData(rtData)
	);

	aluExecute i_aluExecute (
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.imm(imm),
		.res(res)
	);

	resultStage i_resultStage (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.ctrl(ctrl),
		.res(res),
		.rsData(rsData),
		.imm(imm),
		.destIdx(destIdx),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.wbValid(wbValid),
		.wbIdx(wbIdx),
		.wbData(wbData),
		.illegal(illegal),
		.halted(halted)
	);

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/1ps

module resultStage (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input corePkg::ctrl_t ctrl,
	input corePkg::exRes_t res,
	input corePkg::word_t rsData,
	input corePkg::word_t imm,
	input corePkg::regIdx_t destIdx,
	output logic wrEn,
	output corePkg::regIdx_t wrIdx,
	output corePkg::word_t wrData,
	output logic wbValid,
	output corePkg::regIdx_t wbIdx,
	output corePkg::word_t wbData,
	output logic illegal,
	output logic halted
);

	corePkg::word_t wbValue;

	always_comb
	begin
		case (ctrl.srcSel)
			corePkg::SrcAlu: wbValue = res.aluOut;
			corePkg::SrcImm8: wbValue = imm;
			corePkg::SrcSlbi: wbValue = {rsData[7:0], imm[7:0]};
			corePkg::SrcBtr: wbValue = {<<{rsData}};
			corePkg::SrcCond: wbValue = {15'b0, res.cond};
			default: wbValue = res.aluOut;
		endcase
	end

	// A halted core ignores every strobe
	assign wrEn = instValid && ctrl.regWrite && !halted;
	assign wrIdx = destIdx;
	assign wrData = wbValue;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wbValid <= 1'b0;
			illegal <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			wbValid <= wrEn;
			illegal <= instValid && ctrl.illegal && !halted;
			if (instValid && ctrl.halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			wbIdx <= destIdx;
			wbData <= wbValue;
		end
	end

	// A trapped opcode never reaches the register file
	assert property (@(posedge clk) disable iff (!rstN)
		instValid && ctrl.illegal |-> !ctrl.regWrite);

	// Every write names one of the five writeback sources
	assert property (@(posedge clk) disable iff (!rstN)
		wrEn |-> ctrl.srcSel <= corePkg::SrcCond);

endmodule

// ==== design/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute (
	input corePkg::ctrl_t ctrl,
	input corePkg::word_t rsData,
	input corePkg::word_t rtData,
	input corePkg::word_t imm,
	output corePkg::exRes_t res
);

	corePkg::word_t opB;
	corePkg::word_t addA;
	corePkg::word_t addB;
	corePkg::word_t sum;
	logic [31:0] rolWide;
	logic [31:0] rorWide;
	logic [3:0] shAmt;
	logic carry;
	logic overflow;
	logic zero;
	logic signLess;

	assign opB = ctrl.useImm ? imm : rtData;
	assign addA = ctrl.invA ? ~rsData : rsData;
	assign addB = ctrl.invB ? ~opB : opB;

	assign {carry, sum} = {1'b0, addA} + {1'b0, addB} + {16'b0, ctrl.cin};

	// Flags of B - Rs as computed for the compares
	assign overflow = (addA[15] == addB[15]) && (sum[15] != addA[15]);
	assign zero = (sum == '0);
	assign signLess = sum[15] ^ overflow;

	// Rotates work on a doubled copy so a zero amount needs no special case
	assign shAmt = opB[3:0];
	assign rolWide = {rsData, rsData} << shAmt;
	assign rorWide = {rsData, rsData} >> shAmt;

	always_comb
	begin
		case (ctrl.aluOp)
			corePkg::OpRol: res.aluOut = rolWide[31:16];
			corePkg::OpSll: res.aluOut = rsData << shAmt;
			corePkg::OpRor: res.aluOut = rorWide[15:0];
			corePkg::OpSrl: res.aluOut = rsData >> shAmt;
			corePkg::OpOr: res.aluOut = addA | addB;
			corePkg::OpXor: res.aluOut = addA ^ addB;
			corePkg::OpAnd: res.aluOut = addA & addB;
			default: res.aluOut = sum;
		endcase
		res.carry = carry;
		case (ctrl.condSel)
			corePkg::CondEq: res.cond = zero;
			// Rs < Rt means Rt - Rs is strictly positive
			corePkg::CondLt: res.cond = !zero && !signLess;
			corePkg::CondLe: res.cond = !signLess;
			default: res.cond = carry;
		endcase
	end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic wrEn,
	input corePkg::regIdx_t wrIdx,
	input corePkg::word_t wrData,
	input corePkg::regIdx_t rsIdx,
	input corePkg::regIdx_t rtIdx,
	output corePkg::word_t rsData,
	output corePkg::word_t rtData
);

	corePkg::word_t regs [corePkg::RegCount];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < corePkg::RegCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrIdx] <= wrData;
		end
	end

	// No bypass, a dependent read sees the value written at the previous edge
	assign rsData = regs[rsIdx];
	assign rtData = regs[rtIdx];

endmodule

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
	input corePkg::instr_t instr,
	output corePkg::ctrl_t ctrl,
	output corePkg::regIdx_t rsIdx,
	output corePkg::regIdx_t rtIdx,
	output corePkg::regIdx_t destIdx,
	output corePkg::word_t imm
);

	corePkg::opcode_t opcode;
	corePkg::func_t fn;
	corePkg::regIdx_t rdIdx;
	corePkg::word_t sext5;
	corePkg::word_t zext5;
	corePkg::word_t sext8;
	corePkg::word_t zext8;

	assign opcode = instr[15:11];
	assign fn = instr[1:0];
	assign rsIdx = instr[10:8];
	assign rtIdx = instr[7:5];
	assign rdIdx = instr[4:2];

	assign sext5 = {{11{instr[4]}}, instr[4:0]};
	assign zext5 = {11'b0, instr[4:0]};
	assign sext8 = {{8{instr[7]}}, instr[7:0]};
	assign zext8 = {8'b0, instr[7:0]};

	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = corePkg::OpAdd;
		ctrl.srcSel = corePkg::SrcAlu;
		ctrl.condSel = corePkg::CondEq;
		destIdx = rdIdx;
		imm = zext5;
		case (opcode)
			corePkg::OpcAddi, corePkg::OpcSubi:
			begin
				// SUBI is imm - Rs
				ctrl.useImm = 1'b1;
				ctrl.invA = opcode[0];
				ctrl.cin = opcode[0];
				ctrl.regWrite = 1'b1;
				destIdx = rtIdx;
				imm = sext5;
			end
			corePkg::OpcXori, corePkg::OpcAndni:
			begin
				ctrl.aluOp = (opcode == corePkg::OpcXori) ? corePkg::OpXor : corePkg::OpAnd;
				ctrl.invB = (opcode == corePkg::OpcAndni);
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				destIdx = rtIdx;
			end
			corePkg::OpcRoli, corePkg::OpcSlli, corePkg::OpcRori, corePkg::OpcSrli:
			begin
				ctrl.aluOp = corePkg::aluOp_t'({1'b0, opcode[1:0]});
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				destIdx = rtIdx;
			end
			corePkg::OpcShiftR:
			begin
				ctrl.aluOp = corePkg::aluOp_t'({1'b0, fn});
				ctrl.regWrite = 1'b1;
			end
			corePkg::OpcAluR:
			begin
				ctrl.regWrite = 1'b1;
				case (fn)
					corePkg::FnAdd: ctrl.aluOp = corePkg::OpAdd;
					corePkg::FnSub:
					begin
						ctrl.invA = 1'b1;
						ctrl.cin = 1'b1;
					end
					corePkg::FnXor: ctrl.aluOp = corePkg::OpXor;
					corePkg::FnAndn:
					begin
						ctrl.aluOp = corePkg::OpAnd;
						ctrl.invB = 1'b1;
					end
				endcase
			end
			corePkg::OpcSeq, corePkg::OpcSlt, corePkg::OpcSle, corePkg::OpcSco:
			begin
				// Rt - Rs for compares, plain Rs + Rt for SCO
				ctrl.condSel = corePkg::condSel_t'(opcode[1:0]);
				ctrl.invA = (opcode != corePkg::OpcSco);
				ctrl.cin = (opcode != corePkg::OpcSco);
				ctrl.srcSel = corePkg::SrcCond;
				ctrl.regWrite = 1'b1;
			end
			corePkg::OpcBtr:
			begin
				ctrl.srcSel = corePkg::SrcBtr;
				ctrl.regWrite = 1'b1;
			end
			corePkg::OpcLbi, corePkg::OpcSlbi:
			begin
				ctrl.srcSel = (opcode == corePkg::OpcLbi) ? corePkg::SrcImm8 : corePkg::SrcSlbi;
				ctrl.regWrite = 1'b1;
				destIdx = rsIdx;
				imm = (opcode == corePkg::OpcLbi) ? sext8 : zext8;
			end
			corePkg::OpcNop:
			begin
				ctrl.regWrite = 1'b0;
			end
			corePkg::OpcHalt:
			begin
				ctrl.halt = 1'b1;
			end
			default:
			begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/corePkg.sv ====
package corePkg;

	localparam int WordWidth = 16;
	localparam int IdxWidth = 3;
	localparam int RegCount = 8;
	localparam int OpcWidth = 5;
	localparam int FnWidth = 2;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [IdxWidth-1:0] regIdx_t;
	typedef logic [OpcWidth-1:0] opcode_t;
	typedef logic [FnWidth-1:0] func_t;
	typedef logic [WordWidth-1:0] instr_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [2:0] srcSel_t;
	typedef logic [1:0] condSel_t;

	// ALU operations, low two bits of the shift group match the shift fn field
	localparam aluOp_t OpRol = 3'b000;
	localparam aluOp_t OpSll = 3'b001;
	localparam aluOp_t OpRor = 3'b010;
	localparam aluOp_t OpSrl = 3'b011;
	localparam aluOp_t OpAdd = 3'b100;
	localparam aluOp_t OpOr = 3'b101;
	localparam aluOp_t OpXor = 3'b110;
	localparam aluOp_t OpAnd = 3'b111;

	localparam srcSel_t SrcAlu = 3'd0;
	localparam srcSel_t SrcImm8 = 3'd1;
	localparam srcSel_t SrcSlbi = 3'd2;
	localparam srcSel_t SrcBtr = 3'd3;
	localparam srcSel_t SrcCond = 3'd4;

	// Same order as the low opcode bits of SEQ, SLT, SLE, SCO
	localparam condSel_t CondEq = 2'd0;
	localparam condSel_t CondLt = 2'd1;
	localparam condSel_t CondLe = 2'd2;
	localparam condSel_t CondCarry = 2'd3;

	localparam opcode_t OpcHalt = 5'b00000;
	localparam opcode_t OpcNop = 5'b00001;
	localparam opcode_t OpcAddi = 5'b01000;
	localparam opcode_t OpcSubi = 5'b01001;
	localparam opcode_t OpcXori = 5'b01010;
	localparam opcode_t OpcAndni = 5'b01011;
	localparam opcode_t OpcSlbi = 5'b10010;
	localparam opcode_t OpcRoli = 5'b10100;
	localparam opcode_t OpcSlli = 5'b10101;
	localparam opcode_t OpcRori = 5'b10110;
	localparam opcode_t OpcSrli = 5'b10111;
	localparam opcode_t OpcLbi = 5'b11000;
	localparam opcode_t OpcBtr = 5'b11001;
	localparam opcode_t OpcShiftR = 5'b11010;
	localparam opcode_t OpcAluR = 5'b11011;
	localparam opcode_t OpcSeq = 5'b11100;
	localparam opcode_t OpcSlt = 5'b11101;
	localparam opcode_t OpcSle = 5'b11110;
	localparam opcode_t OpcSco = 5'b11111;

	// fn field of the register ALU group
	localparam func_t FnAdd = 2'b00;
	localparam func_t FnSub = 2'b01;
	localparam func_t FnXor = 2'b10;
	localparam func_t FnAndn = 2'b11;

	typedef struct packed {
		aluOp_t aluOp;
		srcSel_t srcSel;
		condSel_t condSel;
		logic useImm;
		logic invA;
		logic invB;
		logic cin;
		logic regWrite;
		logic halt;
		logic illegal;
	} ctrl_t;

	typedef struct packed {
		word_t aluOut;
		logic cond;
		logic carry;
	} exRes_t;

endpackage
